// File: rtl/key_debouncer.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module key_debouncer (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  frame_done,
    input  wire logic                  frame_hit,
    input  wire keypad_pkg::key_code_t frame_code,
    output logic                       key_held,
    output keypad_pkg::key_code_t      key_code,
    output logic                       key_press
);

    localparam int cnt_w = $clog2(`KEY_DEBOUNCE + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`KEY_DEBOUNCE - 1);

    // Frames matched so far, press or release depending on key_held
    logic [cnt_w-1:0]      stable_cnt;
    keypad_pkg::key_code_t cand_code;
    logic                  same_code;
    logic                  accept;

    assign same_code = (stable_cnt != '0) && (frame_code == cand_code);
    assign accept    = frame_done && !key_held && frame_hit && same_code
                       && (stable_cnt == cnt_last);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            key_held   <= 1'b0;
            key_press  <= 1'b0;
            stable_cnt <= '0;
        end else begin
            key_press <= 1'b0;
            if (frame_done) begin
                if (!key_held) begin
                    if (!frame_hit) begin
                        stable_cnt <= '0;
                    end else if (accept) begin
                        key_held   <= 1'b1;
                        key_press  <= 1'b1;
                        stable_cnt <= '0;
                    end else if (same_code) begin
                        stable_cnt <= stable_cnt + cnt_w'(1);
                    end else begin
                        // New candidate restarts the count
                        stable_cnt <= cnt_w'(1);
                    end
                end else if (frame_hit) begin
                    stable_cnt <= '0;
                end else if (stable_cnt == cnt_last) begin
                    key_held   <= 1'b0;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + cnt_w'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done && frame_hit && !key_held) begin
            cand_code <= frame_code;
        end
        if (accept) begin
            key_code <= cand_code;
        end
    end

endmodule

`default_nettype wire

// File: rtl/keypad_config.svh
`ifndef KEYPAD_CONFIG_SVH
`define KEYPAD_CONFIG_SVH

// Cycles each keypad column stays driven low
`define KEY_SCAN_DIV 4

// Identical frames to accept a press, empty frames to accept a release
`define KEY_DEBOUNCE 3

// Cycles each display digit stays lit
`define SEG_SCAN_DIV 4

// Display width in digits
`define SEG_DIGITS 8

`endif

// File: rtl/keypad_menu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module keypad_menu_top (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire keypad_pkg::line_t row,
    output keypad_pkg::line_t      col,
    output keypad_pkg::seg_t       seg,
    output keypad_pkg::an_t        an
);

    logic                       frame_done;
    logic                       frame_hit;
    keypad_pkg::key_code_t      frame_code;
    logic                       key_held;
    keypad_pkg::key_code_t      key_code;
    logic                       key_press;
    logic [4*`SEG_DIGITS-1:0]   digits;
    keypad_pkg::an_t            dots;

    keypad_scanner u_scanner (
        .clk        (clk),
        .reset_n    (reset_n),
        .row        (row),
        .col        (col),
        .frame_done (frame_done),
        .frame_hit  (frame_hit),
        .frame_code (frame_code)
    );

    key_debouncer u_debouncer (
        .clk        (clk),
        .reset_n    (reset_n),
        .frame_done (frame_done),
        .frame_hit  (frame_hit),
        .frame_code (frame_code),
        .key_held   (key_held),
        .key_code   (key_code),
        .key_press  (key_press)
    );

    menu_controller u_menu (
        .clk        (clk),
        .reset_n    (reset_n),
        .key_press  (key_press),
        .key_code   (key_code),
        .digits     (digits),
        .dots       (dots)
    );

    segment_scan u_display (
        .clk        (clk),
        .reset_n    (reset_n),
        .digits     (digits),
        .dots       (dots),
        .seg        (seg),
        .an         (an)
    );

endmodule

`default_nettype wire

// File: rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    typedef logic [3:0] key_code_t;
    typedef logic [3:0] line_t;
    typedef logic [3:0] digit_t;
    typedef logic [7:0] seg_t;
    typedef logic [7:0] an_t;
    typedef logic [1:0] page_t;

    typedef enum logic [0:0] {
        mode_browse,
        mode_entered
    } menu_mode_t;

    // Navigation keys, code is row * 4 + column
    localparam key_code_t key_left   = 4'd0;
    localparam key_code_t key_right  = 4'd1;
    localparam key_code_t key_return = 4'd4;
    localparam key_code_t key_enter  = 4'd5;

    // Active-low {dp, g, f, e, d, c, b, a}
    function automatic seg_t glyph(digit_t d);
        case (d)
            4'h0:    glyph = 8'hc0;
            4'h1:    glyph = 8'hf9;
            4'h2:    glyph = 8'ha4;
            4'h3:    glyph = 8'hb0;
            4'h4:    glyph = 8'h99;
            4'h5:    glyph = 8'h92;
            4'h6:    glyph = 8'h82;
            4'h7:    glyph = 8'hf8;
            4'h8:    glyph = 8'h80;
            4'h9:    glyph = 8'h90;
            4'ha:    glyph = 8'h88;
            4'hb:    glyph = 8'h83;
            4'hc:    glyph = 8'hc6;
            4'hd:    glyph = 8'ha1;
            4'he:    glyph = 8'h86;
            default: glyph = 8'h8e;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module keypad_scanner (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire keypad_pkg::line_t     row,
    output keypad_pkg::line_t          col,
    output logic                       frame_done,
    output logic                       frame_hit,
    output keypad_pkg::key_code_t      frame_code
);

    localparam int div_w = $clog2(`KEY_SCAN_DIV);
    localparam logic [div_w-1:0] div_last = div_w'(`KEY_SCAN_DIV - 1);

    logic [div_w-1:0]      div_cnt;
    logic [1:0]            col_idx;
    logic                  sample;
    logic                  acc_hit;
    keypad_pkg::key_code_t acc_code;
    logic                  col_hit;
    keypad_pkg::key_code_t col_code;
    logic                  merge_hit;
    keypad_pkg::key_code_t merge_code;

    assign sample = (div_cnt == div_last);
    assign col    = ~(keypad_pkg::line_t'(1) << col_idx);

    // Lowest pressed row in the active column
    always_comb begin
        col_hit  = 1'b0;
        col_code = '0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) begin
                col_hit  = 1'b1;
                col_code = {2'(r), col_idx};
            end
        end
    end

    always_comb begin
        merge_hit  = acc_hit | col_hit;
        merge_code = acc_code;
        if (col_hit && (!acc_hit || col_code < acc_code)) begin
            merge_code = col_code;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            div_cnt    <= '0;
            col_idx    <= '0;
            acc_hit    <= 1'b0;
            frame_done <= 1'b0;
            frame_hit  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (sample) begin
                div_cnt <= '0;
                col_idx <= col_idx + 2'd1;
                if (col_idx == 2'd3) begin
                    acc_hit    <= 1'b0;
                    frame_done <= 1'b1;
                    frame_hit  <= merge_hit;
                end else begin
                    acc_hit <= merge_hit;
                end
            end else begin
                div_cnt <= div_cnt + div_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            acc_code <= merge_code;
            if (col_idx == 2'd3) begin
                frame_code <= merge_code;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/menu_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module menu_controller (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  key_press,
    input  wire keypad_pkg::key_code_t key_code,
    output logic [4*`SEG_DIGITS-1:0]   digits,
    output keypad_pkg::an_t            dots
);

    keypad_pkg::menu_mode_t mode;
    keypad_pkg::page_t      page;
    keypad_pkg::key_code_t  last_code;

    //////////////////////////////////////////////////////////////////////
    // Page and mode FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mode      <= keypad_pkg::mode_browse;
            page      <= '0;
            last_code <= '0;
        end else if (key_press) begin
            last_code <= key_code;
            case (mode)
                keypad_pkg::mode_browse: begin
                    if (key_code == keypad_pkg::key_right) begin
                        page <= page + 2'd1;
                    end else if (key_code == keypad_pkg::key_left) begin
                        page <= page - 2'd1;
                    end else if (key_code == keypad_pkg::key_enter) begin
                        mode <= keypad_pkg::mode_entered;
                    end
                end
                keypad_pkg::mode_entered: begin
                    // Only return leaves the page
                    if (key_code == keypad_pkg::key_return) begin
                        mode <= keypad_pkg::mode_browse;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Digit codes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `SEG_DIGITS; i++) begin
            digits[4*i +: 4] = keypad_pkg::digit_t'(page);
        end
        dots = '1;
        if (mode == keypad_pkg::mode_browse) begin
            // Digit 0 echoes the last key
            digits[3:0] = last_code;
        end else begin
            dots[`SEG_DIGITS-1] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/segment_scan.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module segment_scan (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire logic [4*`SEG_DIGITS-1:0]  digits,
    input  wire keypad_pkg::an_t           dots,
    output keypad_pkg::seg_t               seg,
    output keypad_pkg::an_t                an
);

    localparam int div_w = $clog2(`SEG_SCAN_DIV);
    localparam logic [div_w-1:0] div_last = div_w'(`SEG_SCAN_DIV - 1);
    localparam int idx_w = $clog2(`SEG_DIGITS);
    localparam logic [idx_w-1:0] idx_last = idx_w'(`SEG_DIGITS - 1);

    logic [div_w-1:0]   div_cnt;
    logic [idx_w-1:0]   dig_idx;
    keypad_pkg::digit_t cur_digit;
    keypad_pkg::seg_t   seg_next;

    always_comb begin
        cur_digit   = digits[4*dig_idx +: 4];
        seg_next    = keypad_pkg::glyph(cur_digit);
        seg_next[7] = dots[dig_idx];
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            div_cnt <= '0;
            dig_idx <= '0;
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;
            dig_idx <= (dig_idx == idx_last) ? '0 : dig_idx + idx_w'(1);
        end else begin
            div_cnt <= div_cnt + div_w'(1);
        end
    end

    // Both outputs come from the same index, so they switch together
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            an  <= ~keypad_pkg::an_t'(1);
            seg <= '1;
        end else begin
            an  <= ~(keypad_pkg::an_t'(1) << dig_idx);
            seg <= seg_next;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the keypad menu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module keypad_menu_tb -Mdir obj_dir \
    && ./obj_dir/Vkeypad_menu_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// File: verification/keypad_menu_props.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_menu_props (
    input wire logic              clk,
    input wire logic              reset_n,
    input wire keypad_pkg::line_t col,
    input wire keypad_pkg::an_t   an,
    input wire logic              key_press,
    input wire logic              key_held
);

    // Keypad drive, one column at a time
    col_one_low: assert property (
        @(posedge clk) disable iff (!reset_n)
        $countones(~col) == 1
    ) else $error("col has %0d low bits: %b", $countones(~col), col);

    // Display drive, one digit at a time
    an_one_low: assert property (
        @(posedge clk) disable iff (!reset_n)
        $countones(~an) == 1
    ) else $error("an has %0d low bits: %b", $countones(~an), an);

    press_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n)
        key_press |=> !key_press
    ) else $error("key_press lasted more than one cycle");

    press_needs_held: assert property (
        @(posedge clk) disable iff (!reset_n)
        key_press |-> key_held
    ) else $error("key_press without key_held");

endmodule

`default_nettype wire

// File: verification/keypad_menu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "keypad_config.svh"

module keypad_menu_tb;

    localparam int frame_cycles   = 4 * `KEY_SCAN_DIV;
    localparam int refresh_cycles = `SEG_SCAN_DIV * `SEG_DIGITS;
    // About 40 actions of 256 cycles, plus margin
    localparam int timeout_cycles = 20000;

    logic                  clk;
    logic                  reset_n;
    keypad_pkg::line_t     row;
    keypad_pkg::line_t     col;
    keypad_pkg::seg_t      seg;
    keypad_pkg::an_t       an;

    logic                  key_down;
    keypad_pkg::key_code_t key_sel;

    // Expected menu state
    logic                  exp_entered;
    keypad_pkg::page_t     exp_page;
    keypad_pkg::key_code_t exp_code;

    int                    errors;
    int                    test_start_errors;
    int                    tests_passed;
    int                    tests_failed;
    int                    cycle_cnt;
    integer                seed;

    keypad_menu_top dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .row     (row),
        .col     (col),
        .seg     (seg),
        .an      (an)
    );

    bind keypad_menu_top keypad_menu_props props_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .col       (col),
        .an        (an),
        .key_press (key_press),
        .key_held  (key_held)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Keypad model
    //////////////////////////////////////////////////////////////////////

    // Held key pulls its row low while its column is strobed
    initial begin
        row = '1;
        forever begin
            @(posedge clk);
            if (key_down && !col[key_sel[1:0]]) begin
                row <= ~(keypad_pkg::line_t'(1) << key_sel[3:2]);
            end else begin
                row <= '1;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: no result after %0d cycles", cycle_cnt);
        $display("sim failed");
        $finish;
    end

    // Returns {entered, page, last code}
    function automatic logic [6:0] next_state(input logic entered,
                                              input keypad_pkg::page_t page,
                                              input keypad_pkg::key_code_t code,
                                              input keypad_pkg::key_code_t key);
        logic entered_n;
        int   page_n;
        entered_n = entered;
        page_n    = int'(page);
        if (!entered) begin
            if (key == keypad_pkg::key_right) begin
                page_n = (page_n + 1) % 4;
            end else if (key == keypad_pkg::key_left) begin
                page_n = (page_n + 3) % 4;
            end else if (key == keypad_pkg::key_enter) begin
                entered_n = 1'b1;
            end
        end else if (key == keypad_pkg::key_return) begin
            entered_n = 1'b0;
        end
        return {entered_n, 2'(page_n), key};
    endfunction

    function automatic keypad_pkg::seg_t expected_seg(input int idx);
        keypad_pkg::digit_t d;
        keypad_pkg::seg_t   s;
        d = keypad_pkg::digit_t'(exp_page);
        if (!exp_entered && idx == 0) begin
            d = exp_code;
        end
        s    = keypad_pkg::glyph(d);
        s[7] = !(exp_entered && idx == `SEG_DIGITS - 1);
        return s;
    endfunction

    task automatic press_key(input keypad_pkg::key_code_t key, input int frames);
        @(posedge clk);
        key_sel  <= key;
        key_down <= 1'b1;
        repeat (frames * frame_cycles) @(posedge clk);
        key_down <= 1'b0;
        repeat (6 * frame_cycles) @(posedge clk);
    endtask

    task automatic tap_key(input keypad_pkg::key_code_t key);
        logic [6:0] nxt;
        press_key(key, 6);
        nxt = next_state(exp_entered, exp_page, exp_code, key);
        {exp_entered, exp_page, exp_code} = nxt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Display capture and compare
    //////////////////////////////////////////////////////////////////////

    // Column 0 strobed and digit 0 enabled while reset is held
    task automatic check_reset_outputs();
        assert (col === 4'b1110) else begin
            $display("mismatch col after reset: expected %h, actual %h", 4'b1110, col);
            errors++;
        end
        assert (an === 8'hfe) else begin
            $display("mismatch an after reset: expected %h, actual %h", 8'hfe, an);
            errors++;
        end
    endtask

    task automatic check_display();
        keypad_pkg::seg_t       cap [`SEG_DIGITS];
        logic [`SEG_DIGITS-1:0] seen;
        keypad_pkg::an_t        prev_an;
        int                     idx;
        int                     waited;
        seen    = '0;
        prev_an = '1;
        waited  = 0;
        while (seen != '1 && waited < 3 * refresh_cycles) begin
            @(negedge clk);
            waited++;
            assert ($countones(~an) == 1) else begin
                $display("an enables %0d digits at once instead of one", $countones(~an));
                errors++;
            end
            idx = 0;
            for (int i = 0; i < `SEG_DIGITS; i++) begin
                if (!an[i]) begin
                    idx = i;
                end
            end
            // First cycle of each digit is skipped
            if (an == prev_an && $countones(~an) == 1) begin
                cap[idx]  = seg;
                seen[idx] = 1'b1;
            end
            prev_an = an;
        end
        assert (seen == '1) else begin
            $display("display refresh did not light every digit within %0d cycles", waited);
            errors++;
        end
        for (int i = 0; i < `SEG_DIGITS; i++) begin
            if (seen[i]) begin
                assert (cap[i] === expected_seg(i)) else begin
                    $display("mismatch seg digit %0d: expected %h, actual %h",
                             i, expected_seg(i), cap[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        seed              = 95;
        errors            = 0;
        test_start_errors = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        reset_n           = 1'b0;
        key_down          = 1'b0;
        key_sel           = '0;
        exp_entered       = 1'b0;
        exp_page          = '0;
        exp_code          = '0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (refresh_cycles) @(posedge clk);

        check_display();
        finish_test("reset");

        repeat (5) begin
            tap_key(keypad_pkg::key_right);
            check_display();
        end
        finish_test("right wrap");

        repeat (3) begin
            tap_key(keypad_pkg::key_left);
            check_display();
        end
        finish_test("left wrap");

        tap_key(keypad_pkg::key_enter);
        check_display();
        tap_key(keypad_pkg::key_left);
        check_display();
        tap_key(keypad_pkg::key_right);
        check_display();
        tap_key(keypad_pkg::key_return);
        check_display();
        finish_test("enter and return");

        repeat (20) begin
            tap_key(keypad_pkg::key_code_t'($random(seed)));
            check_display();
        end
        finish_test("random keys");

        // Short glitch on a key that would move the page
        tap_key(keypad_pkg::key_return);
        check_display();
        press_key(keypad_pkg::key_right, 2);
        check_display();
        finish_test("short glitch");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/keypad_pkg.sv
rtl/keypad_scanner.sv
rtl/key_debouncer.sv
rtl/menu_controller.sv
rtl/segment_scan.sv
rtl/keypad_menu_top.sv
verification/keypad_menu_props.sv
verification/keypad_menu_tb.sv
